// ==== Makefile ====
# Verilator build and run of the tile memory wrapper testbench

SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tileMemWrapTb
FILELIST = files.f

OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = TESTS FAILED
PASSMSG  = TESTS PASSED

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BINARY   = $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BINARY)

# Rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG) || ! grep -q "$(PASSMSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/tileMemWrapTb.sv ====
`timescale 1ns/1ps

module tileMemWrapTb;

    localparam int clkPeriod     = 8;
    localparam int resetCycles   = 5;
    localparam int numTests      = 6;
    localparam int cyclesPerTest = 300;   // Generous per-test budget
    localparam int waitLimit     = 50;    // Cycles for any single wait
    localparam tileMemPkg::tileId localId = 8'd3;

    logic                  clock;
    logic                  rstN;
    tileMemPkg::word       pc;
    tileMemPkg::word       instruction;
    tileMemPkg::word       dMemWrData;
    tileMemPkg::word       dMemAddress;
    tileMemPkg::byteEn     dMemByteEn;
    logic                  dMemWrEn;
    logic                  dMemRdEn;
    tileMemPkg::word       dMemRdRsp;
    logic                  dMemReady;
    logic                  inFabricValid;
    tileMemPkg::tileTrans  inFabric;
    logic                  coreReady;
    logic                  outFabricValid;
    tileMemPkg::tileTrans  outFabric;
    logic                  fabReady;

    logic [15:0]           lfsrState;
    tileMemPkg::word       dWords [8];    // Data region words written in the read test
    tileMemPkg::tileTrans  outSeen [$];   // Fabric model receive queue

    tileMemWrap #(.iMemAdrsWidth(10), .dMemAdrsWidth(10), .fifoDepth(2)) tileMemWrap_i (
        .clock          (clock),
        .rstN           (rstN),
        .localTileId    (localId),
        .pc             (pc),
        .instruction    (instruction),
        .dMemWrData     (dMemWrData),
        .dMemAddress    (dMemAddress),
        .dMemByteEn     (dMemByteEn),
        .dMemWrEn       (dMemWrEn),
        .dMemRdEn       (dMemRdEn),
        .dMemRdRsp      (dMemRdRsp),
        .dMemReady      (dMemReady),
        .inFabricValid  (inFabricValid),
        .inFabric       (inFabric),
        .coreReady      (coreReady),
        .outFabricValid (outFabricValid),
        .outFabric      (outFabric),
        .fabReady       (fabReady)
    );

    // ====================
    // Clock, watchdog, fabric model
    // ====================
    initial begin
        clock = 1'b0;
        forever #(clkPeriod / 2) clock = ~clock;
    end

    initial begin
        #(numTests * cyclesPerTest * clkPeriod);
        abortRun("Watchdog expired before the tests finished");
    end

    // Every accepted outgoing transaction, seen like a flop would
    always @(posedge clock) begin
        if (rstN && outFabricValid) begin
            outSeen.push_back(outFabric);
        end
    end

    // ====================
    // Helpers
    // ====================
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic compareValues(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp));
        end
    endtask

    // Galois form, taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic nextRandomWord(output tileMemPkg::word w);
        for (int i = 0; i < 32; i++) begin
            w[i]      = lfsrState[0];   // One step per bit
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    function automatic tileMemPkg::tileTrans makeTrans(input tileMemPkg::word address,
            input tileMemPkg::word data, input tileMemPkg::opcode op,
            input tileMemPkg::tileId rid);
        tileMemPkg::tileTrans t;
        t.address     = address;
        t.data        = data;
        t.opcode      = op;
        t.requestorId = rid;
        return t;
    endfunction

    // All drivers start and end just after a falling edge
    task automatic sendFabric(input tileMemPkg::tileTrans t);
        inFabricValid = 1'b1;
        inFabric      = t;
        @(negedge clock);
        inFabricValid = 1'b0;
    endtask

    task automatic waitDataReady();
        int n;
        n = 0;
        while (!dMemReady) begin
            @(negedge clock);
            n++;
            if (n > waitLimit) abortRun("dMemReady stayed low for too long");
        end
    endtask

    task automatic storeWord(input tileMemPkg::word addr, input tileMemPkg::word data,
                             input tileMemPkg::byteEn be);
        waitDataReady();
        dMemAddress = addr;
        dMemWrData  = data;
        dMemByteEn  = be;
        dMemWrEn    = 1'b1;
        @(negedge clock);
        dMemWrEn    = 1'b0;
    endtask

    task automatic loadWord(input tileMemPkg::word addr, output tileMemPkg::word rsp);
        waitDataReady();
        dMemAddress = addr;
        dMemRdEn    = 1'b1;
        @(negedge clock);
        dMemRdEn    = 1'b0;
        rsp         = dMemRdRsp;   // Registered, one cycle after the strobe
    endtask

    task automatic popOutgoing(output tileMemPkg::tileTrans t);
        int n;
        n = 0;
        while (outSeen.size() == 0) begin
            @(negedge clock);
            n++;
            if (n > waitLimit) abortRun("No transaction appeared on the outgoing fabric");
        end
        t = outSeen.pop_front();
    endtask

    // ====================
    // Tests
    // ====================
    task automatic fabricWriteThenFetch();
        tileMemPkg::word words [8];
        for (int i = 0; i < 8; i++) begin
            nextRandomWord(words[i]);
            sendFabric(makeTrans({localId, 24'h00_0100 + 24'(4 * i)}, words[i],
                                 tileMemPkg::opWr, 8'd1));
        end
        for (int i = 0; i < 8; i++) begin
            pc = 32'h0000_0100 + 32'(4 * i);
            @(negedge clock);
            compareValues("instruction", instruction, words[i]);
        end
    endtask

    task automatic fabricReadResponse();
        tileMemPkg::tileTrans t;
        logic [23:0]          off;
        for (int i = 0; i < 8; i++) begin
            nextRandomWord(dWords[i]);
            sendFabric(makeTrans({localId, 24'h01_0000 + 24'(4 * i)}, dWords[i],
                                 tileMemPkg::opWr, 8'd1));
        end
        for (int i = 0; i < 8; i++) begin
            off = 24'h01_0000 + 24'(4 * i);
            sendFabric(makeTrans({localId, off}, '0, tileMemPkg::opRd, 8'd5));
            popOutgoing(t);
            compareValues("outFabric.opcode", t.opcode, tileMemPkg::opRdRsp);
            compareValues("outFabric.address", t.address, {8'd5, off});  // Back to tile 5
            compareValues("outFabric.data", t.data, dWords[i]);
            compareValues("outFabric.requestorId", t.requestorId, localId);
        end
    endtask

    task automatic byteHalfAccess();
        tileMemPkg::word base;
        tileMemPkg::word model;
        tileMemPkg::word w;
        tileMemPkg::word rsp;
        base = 32'h0301_0040;
        nextRandomWord(model);
        storeWord(base, model, 4'hF);
        for (int size = 1; size <= 2; size++) begin
            for (int off = 0; off <= 4 - size; off++) begin
                nextRandomWord(w);
                storeWord(base + 32'(off), w, (size == 1) ? 4'b0001 : 4'b0011);
                for (int lane = 0; lane < size; lane++) begin
                    model[8 * (off + lane) +: 8] = w[8 * lane +: 8];  // Lane moves up by off
                end
                loadWord(base, rsp);
                compareValues("dMemRdRsp word", rsp, model);
                loadWord(base + 32'(off), rsp);
                compareValues("dMemRdRsp offset", rsp, model >> (8 * off));
            end
        end
    endtask

    task automatic whoAmIRead();
        tileMemPkg::word rsp;
        loadWord(32'h00FF_FFFF, rsp);
        compareValues("dMemRdRsp whoAmI", rsp, {24'h0, localId});
    endtask

    task automatic remoteRead();
        tileMemPkg::tileTrans t;
        tileMemPkg::word      answer;
        nextRandomWord(answer);
        waitDataReady();
        dMemAddress = 32'h0701_0020;   // Tile 7
        dMemRdEn    = 1'b1;
        @(negedge clock);
        dMemRdEn    = 1'b0;
        compareValues("dMemReady", dMemReady, 1'b0);
        popOutgoing(t);
        compareValues("outFabric.opcode", t.opcode, tileMemPkg::opRd);
        compareValues("outFabric.address", t.address, 32'h0701_0020);
        compareValues("outFabric.requestorId", t.requestorId, localId);
        repeat (3) @(negedge clock);   // Some remote latency
        compareValues("dMemReady", dMemReady, 1'b0);
        sendFabric(makeTrans({localId, 24'h01_0020}, answer, tileMemPkg::opRdRsp, 8'd7));
        waitDataReady();
        compareValues("dMemRdRsp remote", dMemRdRsp, answer);
    endtask

    task automatic backPressureArbitration();
        tileMemPkg::tileTrans t;
        tileMemPkg::word      storeData;
        int                   nStore;
        int                   nRsp;
        nStore = 0;
        nRsp   = 0;
        nextRandomWord(storeData);
        fabReady = 1'b0;
        storeWord(32'h0700_0010, storeData, 4'hF);
        sendFabric(makeTrans({localId, 24'h01_0008}, '0, tileMemPkg::opRd, 8'd9));
        repeat (6) begin
            @(negedge clock);
            compareValues("outFabricValid", outFabricValid, 1'b0);
        end
        compareValues("coreReady", coreReady, 1'b0);   // One response queued
        compareValues("outgoing count stalled", outSeen.size(), 0);
        fabReady = 1'b1;
        repeat (6) @(negedge clock);
        compareValues("outgoing count", outSeen.size(), 2);
        // Request won the last grant in the remote read, so the response goes first
        t = outSeen[0];
        compareValues("first grant opcode", t.opcode, tileMemPkg::opRdRsp);
        while (outSeen.size() > 0) begin
            t = outSeen.pop_front();
            if (t.opcode == tileMemPkg::opWr) begin
                nStore++;
                compareValues("store address", t.address, 32'h0700_0010);
                compareValues("store data", t.data, storeData);
                compareValues("store requestorId", t.requestorId, localId);
            end else if (t.opcode == tileMemPkg::opRdRsp) begin
                nRsp++;
                compareValues("response address", t.address, {8'd9, 24'h01_0008});
                compareValues("response data", t.data, dWords[2]);
                compareValues("response requestorId", t.requestorId, localId);
            end else begin
                abortRun("Unexpected opcode on the outgoing fabric");
            end
        end
        compareValues("store count", nStore, 1);
        compareValues("response count", nRsp, 1);
        compareValues("coreReady", coreReady, 1'b1);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        rstN          = 1'b0;
        pc            = '0;
        dMemWrData    = '0;
        dMemAddress   = '0;
        dMemByteEn    = '0;
        dMemWrEn      = 1'b0;
        dMemRdEn      = 1'b0;
        inFabricValid = 1'b0;
        inFabric      = '0;
        fabReady      = 1'b1;
        lfsrState     = 16'd18609;
        repeat (resetCycles) @(posedge clock);
        @(negedge clock);
        rstN = 1'b1;
        @(negedge clock);
        compareValues("outFabricValid after reset", outFabricValid, 1'b0);
        compareValues("dMemReady after reset", dMemReady, 1'b1);
        compareValues("coreReady after reset", coreReady, 1'b1);

        fabricWriteThenFetch();
        fabricReadResponse();
        byteHalfAccess();
        whoAmIRead();
        remoteRead();
        backPressureArbitration();
        repeat (4) @(negedge clock);   // Fabric must stay quiet
        compareValues("leftover outgoing count", outSeen.size(), 0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
hw/tileMemPkg.sv
hw/dualPortRam.sv
hw/coreDataPort.sv
hw/fabricTarget.sv
hw/transFifo.sv
hw/fabricOutArbiter.sv
hw/tileMemWrap.sv
bench/tileMemWrapTb.sv

// ==== hw/coreDataPort.sv ====
`timescale 1ns/1ps

module coreDataPort #(
    parameter int dMemAdrsWidth = 10
) (
    input  logic                      clock,
    input  logic                      rstN,
    input  tileMemPkg::tileId         localTileId,
    // Core data strobes
    input  tileMemPkg::word           dMemWrData,
    input  tileMemPkg::word           dMemAddress,
    input  tileMemPkg::byteEn         dMemByteEn,
    input  logic                      dMemWrEn,
    input  logic                      dMemRdEn,
    // Data RAM port A
    output logic [dMemAdrsWidth-1:0]  ramAddress,
    output tileMemPkg::word           ramWrData,
    output logic                      ramWrEn,
    output tileMemPkg::byteEn         ramByteEn,
    input  tileMemPkg::word           ramRdData,
    // Fabric responses back to the core
    input  logic                      inFabricValid,
    input  tileMemPkg::tileTrans      inFabric,
    // Request FIFO
    input  logic                      reqFull,
    output logic                      reqPush,
    output tileMemPkg::tileTrans      reqTrans,
    // Core return path
    output tileMemPkg::word           dMemRdRsp,
    output logic                      dMemReady
);

    logic            isLocal;
    logic            isRemote;
    logic            whoAmIReq;
    logic            whoAmIQ;       // WhoAmI read last cycle
    logic [1:0]      lowAdrsQ;      // Byte offset of last read
    logic            outstanding;   // Remote read in flight
    logic            rspArrive;
    logic            fabRspValidQ;
    tileMemPkg::word fabRspDataQ;

    // ====================
    // Address decode
    // ====================
    assign isLocal  = (dMemAddress[31:24] == localTileId) || (dMemAddress[31:24] == 8'h00);
    assign isRemote = (dMemWrEn || dMemRdEn) && !isLocal;
    assign whoAmIReq = dMemRdEn && (dMemAddress[31:24] == 8'h00)
                       && (dMemAddress[23:0] == tileMemPkg::whoAmIOffset);

    // Local access, aligned by the low address bits
    assign ramAddress = dMemAddress[dMemAdrsWidth+1:2];
    assign ramWrData  = dMemWrData << {dMemAddress[1:0], 3'b000};
    assign ramByteEn  = dMemByteEn << dMemAddress[1:0];
    assign ramWrEn    = dMemWrEn && isLocal;

    // ====================
    // Remote request
    // ====================
    assign reqPush = isRemote;  // Core strobes only while ready
    always_comb begin
        reqTrans.address     = dMemAddress;
        reqTrans.data        = dMemWrData;
        reqTrans.opcode      = dMemWrEn ? tileMemPkg::opWr : tileMemPkg::opRd;
        reqTrans.requestorId = localTileId;
    end

    assign rspArrive = inFabricValid && (inFabric.opcode == tileMemPkg::opRdRsp);

    // Outstanding flag, set by a remote load and cleared by its response
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            outstanding  <= 1'b0;
            fabRspValidQ <= 1'b0;
            whoAmIQ      <= 1'b0;
        end else begin
            if (rspArrive) begin
                outstanding <= 1'b0;
            end else if (isRemote && dMemRdEn) begin
                outstanding <= 1'b1;
            end
            fabRspValidQ <= rspArrive && outstanding;  // Only when a load waits
            whoAmIQ      <= whoAmIReq;
        end
    end

    always_ff @(posedge clock) begin
        fabRspDataQ <= inFabric.data;
        lowAdrsQ    <= dMemAddress[1:0];
    end

    // Stall on a pending load or a full request FIFO
    assign dMemReady = !outstanding && !reqFull;

    // ====================
    // Read data mux
    // ====================
    always_comb begin
        if (fabRspValidQ) begin
            dMemRdRsp = fabRspDataQ;                 // Remote load answer
        end else if (whoAmIQ) begin
            dMemRdRsp = {24'h0, localTileId};
        end else begin
            dMemRdRsp = ramRdData >> {lowAdrsQ, 3'b000};  // Sub-word lane to bit 0
        end
    end

endmodule

// ==== hw/dualPortRam.sv ====
`timescale 1ns/1ps

module dualPortRam #(
    parameter int adrsWidth = 10
) (
    input  logic                   clock,
    // Port A
    input  logic [adrsWidth-1:0]   addressA,
    input  tileMemPkg::word        dataA,
    input  logic                   wrEnA,
    input  tileMemPkg::byteEn      byteEnableA,
    output tileMemPkg::word        qA,
    // Port B
    input  logic [adrsWidth-1:0]   addressB,
    input  tileMemPkg::word        dataB,
    input  logic                   wrEnB,
    input  tileMemPkg::byteEn      byteEnableB,
    output tileMemPkg::word        qB
);

    tileMemPkg::word mem [2**adrsWidth];  // Word array

    // Both ports write per lane, B wins on a same-address collision
    always_ff @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (wrEnA && byteEnableA[i]) begin
                mem[addressA][8*i +: 8] <= dataA[8*i +: 8];
            end
            if (wrEnB && byteEnableB[i]) begin
                mem[addressB][8*i +: 8] <= dataB[8*i +: 8];
            end
        end
        qA <= mem[addressA];  // Old data on read during write
        qB <= mem[addressB];
    end

endmodule

// ==== hw/fabricOutArbiter.sv ====
`timescale 1ns/1ps

module fabricOutArbiter (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic                  rspEmpty,
    input  logic                  reqEmpty,
    input  tileMemPkg::tileTrans  rspHead,
    input  tileMemPkg::tileTrans  reqHead,
    input  logic                  fabReady,
    output logic                  rspPop,
    output logic                  reqPop,
    output logic                  outFabricValid,
    output tileMemPkg::tileTrans  outFabric
);

    logic rspCand;
    logic reqCand;
    logic lastWasReq;  // Winner of the last grant

    // Candidates only while the fabric takes data
    assign rspCand = !rspEmpty && fabReady;
    assign reqCand = !reqEmpty && fabReady;

    // Round robin over two clients
    assign rspPop = rspCand && (!reqCand || lastWasReq);
    assign reqPop = reqCand && !rspPop;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            lastWasReq <= 1'b1;   // Responses first out of reset
        end else if (rspPop || reqPop) begin
            lastWasReq <= reqPop;
        end
    end

    // Output mux
    assign outFabricValid = rspPop || reqPop;
    assign outFabric      = rspPop ? rspHead :
                            reqPop ? reqHead :
                                     '0;

endmodule

// ==== hw/fabricTarget.sv ====
`timescale 1ns/1ps

module fabricTarget (
    input  logic                  clock,
    input  logic                  rstN,
    input  tileMemPkg::tileId     localTileId,
    input  logic                  inFabricValid,
    input  tileMemPkg::tileTrans  inFabric,
    output logic                  iMemWrEn,
    output logic                  dMemWrEn,
    input  tileMemPkg::word       iMemRdData,   // RAM port B, one cycle late
    input  tileMemPkg::word       dMemRdData,
    output logic                  rspPush,
    output tileMemPkg::tileTrans  rspTrans
);

    logic [23:0]     offset;
    logic            iHit;
    logic            dHit;
    logic            rdReq;
    logic            rdValidQ;
    logic            iHitQ;
    logic            dHitQ;
    tileMemPkg::word rspAddressQ;

    // ====================
    // Region decode
    // ====================
    assign offset = inFabric.address[23:0];
    assign iHit = (offset >= tileMemPkg::iMemRegionFloor) && (offset <= tileMemPkg::iMemRegionRoof);
    assign dHit = (offset >= tileMemPkg::dMemRegionFloor) && (offset <= tileMemPkg::dMemRegionRoof);

    // Full word writes
    assign iMemWrEn = inFabricValid && iHit && (inFabric.opcode == tileMemPkg::opWr);
    assign dMemWrEn = inFabricValid && dHit && (inFabric.opcode == tileMemPkg::opWr);
    assign rdReq    = inFabricValid && (inFabric.opcode == tileMemPkg::opRd);

    // ====================
    // Read response
    // ====================
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            rdValidQ <= 1'b0;
            iHitQ    <= 1'b0;
            dHitQ    <= 1'b0;
        end else begin
            rdValidQ <= rdReq;
            iHitQ    <= iHit;
            dHitQ    <= dHit;
        end
    end

    // Response goes back to the requestor tile at the same offset
    always_ff @(posedge clock) begin
        rspAddressQ <= {inFabric.requestorId, offset};
    end

    assign rspPush = rdValidQ;
    always_comb begin
        rspTrans.address     = rspAddressQ;
        rspTrans.data        = iHitQ ? iMemRdData :
                               dHitQ ? dMemRdData :
                                       '0;          // Miss reads zero
        rspTrans.opcode      = tileMemPkg::opRdRsp;
        rspTrans.requestorId = localTileId;
    end

endmodule

// ==== hw/tileMemPkg.sv ====
package tileMemPkg;

    // ====================
    // Basic vectors
    // ====================
    typedef logic [31:0] word;     // Data word and byte address
    typedef logic [3:0]  byteEn;   // One bit per byte lane
    typedef logic [7:0]  tileId;   // Tile number in the top address byte
    typedef logic [1:0]  opcode;   // Fabric transaction kind

    // Fabric opcodes
    localparam opcode opRd    = 2'b00;
    localparam opcode opWr    = 2'b01;
    localparam opcode opRdRsp = 2'b10;

    // ====================
    // Fabric transaction
    // ====================
    // One entry on the fabric and in the FIFOs
    typedef struct packed {
        word   address;      // Target tile id in [31:24]
        word   data;
        opcode opcode;
        tileId requestorId;  // Tile that issued it
    } tileTrans;

    // ====================
    // Address map
    // ====================
    // Offsets below the tile id byte, bounds inclusive
    localparam logic [23:0] whoAmIOffset    = 24'hFF_FFFF;  // Answers local tile id

    localparam logic [23:0] iMemRegionFloor = 24'h00_0000;
    localparam logic [23:0] iMemRegionRoof  = 24'h00_FFFF;

    localparam logic [23:0] dMemRegionFloor = 24'h01_0000;
    localparam logic [23:0] dMemRegionRoof  = 24'h01_FFFF;

endpackage

// ==== hw/tileMemWrap.sv ====
`timescale 1ns/1ps

module tileMemWrap #(
    parameter int iMemAdrsWidth = 10,
    parameter int dMemAdrsWidth = 10,
    parameter int fifoDepth     = 2
) (
    input  logic                  clock,
    input  logic                  rstN,
    input  tileMemPkg::tileId     localTileId,
    // ====================
    // Core side
    // ====================
    input  tileMemPkg::word       pc,
    output tileMemPkg::word       instruction,   // One cycle after pc
    input  tileMemPkg::word       dMemWrData,
    input  tileMemPkg::word       dMemAddress,
    input  tileMemPkg::byteEn     dMemByteEn,
    input  logic                  dMemWrEn,
    input  logic                  dMemRdEn,
    output tileMemPkg::word       dMemRdRsp,
    output logic                  dMemReady,
    // ====================
    // Fabric side
    // ====================
    input  logic                  inFabricValid,
    input  tileMemPkg::tileTrans  inFabric,
    output logic                  coreReady,
    output logic                  outFabricValid,
    output tileMemPkg::tileTrans  outFabric,
    input  logic                  fabReady
);

    // Fabric target to RAMs
    logic                      fabIMemWrEn;
    logic                      fabDMemWrEn;
    tileMemPkg::word           fabIMemRdData;
    tileMemPkg::word           fabDMemRdData;
    // Core port to data RAM
    logic [dMemAdrsWidth-1:0]  dRamAddress;
    tileMemPkg::word           dRamWrData;
    logic                      dRamWrEn;
    tileMemPkg::byteEn         dRamByteEn;
    tileMemPkg::word           dRamRdData;
    // FIFO traffic
    logic                      reqPush;
    logic                      reqPop;
    logic                      reqFull;
    logic                      reqEmpty;
    tileMemPkg::tileTrans      reqTrans;
    tileMemPkg::tileTrans      reqHead;
    logic                      rspPush;
    logic                      rspPop;
    logic                      rspAlmostFull;
    logic                      rspEmpty;
    tileMemPkg::tileTrans      rspTrans;
    tileMemPkg::tileTrans      rspHead;

    // Instruction RAM, port A fetch and port B fabric
    dualPortRam #(.adrsWidth(iMemAdrsWidth)) iMem (
        .clock       (clock),
        .addressA    (pc[iMemAdrsWidth+1:2]),
        .dataA       ('0),
        .wrEnA       (1'b0),                // Fetch only
        .byteEnableA ('0),
        .qA          (instruction),
        .addressB    (inFabric.address[iMemAdrsWidth+1:2]),
        .dataB       (inFabric.data),
        .wrEnB       (fabIMemWrEn),
        .byteEnableB (4'b1111),
        .qB          (fabIMemRdData)
    );

    // Data RAM, port A core and port B fabric
    dualPortRam #(.adrsWidth(dMemAdrsWidth)) dMem (
        .clock       (clock),
        .addressA    (dRamAddress),
        .dataA       (dRamWrData),
        .wrEnA       (dRamWrEn),
        .byteEnableA (dRamByteEn),
        .qA          (dRamRdData),
        .addressB    (inFabric.address[dMemAdrsWidth+1:2]),
        .dataB       (inFabric.data),
        .wrEnB       (fabDMemWrEn),
        .byteEnableB (4'b1111),
        .qB          (fabDMemRdData)
    );

    // ====================
    // Producers
    // ====================
    coreDataPort #(.dMemAdrsWidth(dMemAdrsWidth)) dataPort (
        .clock         (clock),
        .rstN          (rstN),
        .localTileId   (localTileId),
        .dMemWrData    (dMemWrData),
        .dMemAddress   (dMemAddress),
        .dMemByteEn    (dMemByteEn),
        .dMemWrEn      (dMemWrEn),
        .dMemRdEn      (dMemRdEn),
        .ramAddress    (dRamAddress),
        .ramWrData     (dRamWrData),
        .ramWrEn       (dRamWrEn),
        .ramByteEn     (dRamByteEn),
        .ramRdData     (dRamRdData),
        .inFabricValid (inFabricValid),
        .inFabric      (inFabric),
        .reqFull       (reqFull),
        .reqPush       (reqPush),
        .reqTrans      (reqTrans),
        .dMemRdRsp     (dMemRdRsp),
        .dMemReady     (dMemReady)
    );

    fabricTarget fabTarget (
        .clock         (clock),
        .rstN          (rstN),
        .localTileId   (localTileId),
        .inFabricValid (inFabricValid),
        .inFabric      (inFabric),
        .iMemWrEn      (fabIMemWrEn),
        .dMemWrEn      (fabDMemWrEn),
        .iMemRdData    (fabIMemRdData),
        .dMemRdData    (fabDMemRdData),
        .rspPush       (rspPush),
        .rspTrans      (rspTrans)
    );

    // ====================
    // FIFOs and arbiter
    // ====================
    transFifo #(.depth(fifoDepth)) rspFifo (
        .clock      (clock),
        .rstN       (rstN),
        .push       (rspPush),
        .pushData   (rspTrans),
        .pop        (rspPop),
        .popData    (rspHead),
        .full       (),
        .almostFull (rspAlmostFull),
        .empty      (rspEmpty)
    );

    transFifo #(.depth(fifoDepth)) reqFifo (
        .clock      (clock),
        .rstN       (rstN),
        .push       (reqPush),
        .pushData   (reqTrans),
        .pop        (reqPop),
        .popData    (reqHead),
        .full       (reqFull),       // Stalls the core
        .almostFull (),
        .empty      (reqEmpty)
    );

    fabricOutArbiter outArbiter (
        .clock          (clock),
        .rstN           (rstN),
        .rspEmpty       (rspEmpty),
        .reqEmpty       (reqEmpty),
        .rspHead        (rspHead),
        .reqHead        (reqHead),
        .fabReady       (fabReady),
        .rspPop         (rspPop),
        .reqPop         (reqPop),
        .outFabricValid (outFabricValid),
        .outFabric      (outFabric)
    );

    // One spare response entry covers the read pipeline cycle
    assign coreReady = !rspAlmostFull;

endmodule

// ==== hw/transFifo.sv ====
`timescale 1ns/1ps

module transFifo #(
    parameter int depth = 2
) (
    input  logic                  clock,
    input  logic                  rstN,
    input  logic                  push,
    input  tileMemPkg::tileTrans  pushData,
    input  logic                  pop,
    output tileMemPkg::tileTrans  popData,
    output logic                  full,
    output logic                  almostFull,   // At most one free entry
    output logic                  empty
);

    localparam int ptrWidth = $clog2(depth);
    localparam int cntWidth = $clog2(depth + 1);

    tileMemPkg::tileTrans  entries [depth];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [cntWidth-1:0]   count;
    logic                  doPush;
    logic                  doPop;

    assign doPush = push && !full;   // Push into a full FIFO is dropped
    assign doPop  = pop && !empty;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // None or both
            endcase
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (doPush) begin
            entries[wrPtr] <= pushData;
        end
    end

    assign popData    = entries[rdPtr];  // Head, valid while not empty
    assign full       = (count == cntWidth'(depth));
    assign almostFull = (count >= cntWidth'(depth - 1));
    assign empty      = (count == '0);

endmodule
